// File: audio_consts.svh
`ifndef AUDIO_CONSTS_SVH
`define AUDIO_CONSTS_SVH

// register bus
`define AUDIO_ADDR_W      5      // sound register address width
`define AUDIO_DATA_W      8      // cpu data bus width

// voice datapath
`define AUDIO_FREQ_W      16     // phase step per 1 MHz tick
`define AUDIO_PHASE_W     24     // phase accumulator
`define AUDIO_WAVE_W      12     // signed waveform before volume
`define AUDIO_VOL_W       4      // fixed volume per voice
`define AUDIO_SAMPLE_W    16     // signed voice sample and mix

// two tone voices, register map and mixer follow this
`define AUDIO_NUM_VOICES  2

// cb2 click magnitude, same as 16'h800
`define AUDIO_CLICK_LEVEL 2048

`endif

// File: audio_pkg.sv
`default_nettype none

`include "audio_consts.svh"

package audio_pkg;

    // voice waveform, ctrl register bits 1:0
    typedef enum logic [1:0] {
        WAVE_OFF      = 2'd0,  // silence
        WAVE_SAW      = 2'd1,  // phase msb inverted
        WAVE_SQUARE   = 2'd2,  // full scale by phase msb
        WAVE_TRIANGLE = 2'd3   // phase folded at the half
    } wave_e;

    // register map, four registers per voice
    // voice n lives at n*4, the v0 names double as field offsets
    typedef enum logic [`AUDIO_ADDR_W-1:0] {
        REG_V0_FREQ_LO = 5'd0,
        REG_V0_FREQ_HI = 5'd1,
        REG_V0_CTRL    = 5'd2,   // wave and gate
        REG_V0_VOL     = 5'd3,   // volume in 3:0
        REG_V1_FREQ_LO = 5'd4,
        REG_V1_FREQ_HI = 5'd5,
        REG_V1_CTRL    = 5'd6,
        REG_V1_VOL     = 5'd7,
        REG_OSC0       = 5'd27   // read only, voice 0 phase msb byte
    } reg_addr_e;

    // anything else reads back as zero

endpackage

`default_nettype wire

// File: sound_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "audio_consts.svh"

module sound_regs import audio_pkg::*; (
    input  wire logic                                            clk_i,
    input  wire logic                                            reset_i,
    input  wire logic                                            wr_en_i,  // strobe and select
    input  wire logic [`AUDIO_ADDR_W-1:0]                        addr_i,
    input  wire logic [`AUDIO_DATA_W-1:0]                        data_i,
    input  wire logic [`AUDIO_DATA_W-1:0]                        osc0_i,   // voice 0 phase byte
    output logic      [`AUDIO_DATA_W-1:0]                        data_o,
    output logic      [`AUDIO_NUM_VOICES-1:0][`AUDIO_FREQ_W-1:0] freq_o,
    output wave_e     [`AUDIO_NUM_VOICES-1:0]                    wave_o,
    output logic      [`AUDIO_NUM_VOICES-1:0]                    gate_o,
    output logic      [`AUDIO_NUM_VOICES-1:0][`AUDIO_VOL_W-1:0]  vol_o
);
    // byte registers per voice, unused bits never stored
    logic [`AUDIO_DATA_W-1:0] freq_lo_q [`AUDIO_NUM_VOICES];
    logic [`AUDIO_DATA_W-1:0] freq_hi_q [`AUDIO_NUM_VOICES];
    logic [2:0]               ctrl_q    [`AUDIO_NUM_VOICES];  // gate, wave
    logic [`AUDIO_VOL_W-1:0]  vol_q     [`AUDIO_NUM_VOICES];

    // address splits into voice slot and field
    logic [`AUDIO_ADDR_W-3:0] sel_voice;
    reg_addr_e                field;

    assign sel_voice = addr_i[`AUDIO_ADDR_W-1:2];
    assign field     = reg_addr_e'(`AUDIO_ADDR_W'(addr_i[1:0]));  // offset within voice

    // write decode, lands on this edge
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int v = 0; v < `AUDIO_NUM_VOICES; v++) begin
                freq_lo_q[v] <= '0;
                freq_hi_q[v] <= '0;
                ctrl_q[v]    <= '0;
                vol_q[v]     <= '0;
            end
        end else if (wr_en_i) begin
            for (int v = 0; v < `AUDIO_NUM_VOICES; v++) begin
                if (sel_voice == v) begin  // osc0 slot never matches a voice
                    case (field)
                        REG_V0_FREQ_LO: freq_lo_q[v] <= data_i;
                        REG_V0_FREQ_HI: freq_hi_q[v] <= data_i;
                        REG_V0_CTRL:    ctrl_q[v]    <= data_i[2:0];          // mask upper
                        REG_V0_VOL:     vol_q[v]     <= data_i[`AUDIO_VOL_W-1:0];
                        default: ;
                    endcase
                end
            end
        end
    end

    // read back, purely combinational from the address
    always_comb begin
        data_o = '0;  // unmapped reads zero
        if (reg_addr_e'(addr_i) == REG_OSC0) begin
            data_o = osc0_i;
        end
        for (int v = 0; v < `AUDIO_NUM_VOICES; v++) begin
            if (sel_voice == v) begin
                case (field)
                    REG_V0_FREQ_LO: data_o = freq_lo_q[v];
                    REG_V0_FREQ_HI: data_o = freq_hi_q[v];
                    REG_V0_CTRL:    data_o = `AUDIO_DATA_W'(ctrl_q[v]);
                    REG_V0_VOL:     data_o = `AUDIO_DATA_W'(vol_q[v]);
                    default: ;
                endcase
            end
        end
    end

    // fan out to the voices
    always_comb begin
        for (int v = 0; v < `AUDIO_NUM_VOICES; v++) begin
            freq_o[v] = {freq_hi_q[v], freq_lo_q[v]};
            wave_o[v] = wave_e'(ctrl_q[v][1:0]);
            gate_o[v] = ctrl_q[v][2];      // gate low holds phase at zero
            vol_o[v]  = vol_q[v];
        end
    end

endmodule

`default_nettype wire

// File: tone_voice.sv
`timescale 1ns/1ps
`default_nettype none

`include "audio_consts.svh"

module tone_voice import audio_pkg::*; (
    input  wire logic                              clk_i,
    input  wire logic                              reset_i,
    input  wire logic                              step_en_i,  // 1 MHz enable
    input  wire logic        [`AUDIO_FREQ_W-1:0]   freq_i,
    input  wire wave_e                             wave_i,
    input  wire logic                              gate_i,
    input  wire logic        [`AUDIO_VOL_W-1:0]    vol_i,
    output logic signed      [`AUDIO_SAMPLE_W-1:0] sample_o,
    output logic             [`AUDIO_DATA_W-1:0]   osc_o      // phase msb byte
);
    logic [`AUDIO_PHASE_W-1:0]       phase_q;
    logic [`AUDIO_WAVE_W-1:0]        top;       // phase top bits
    logic [`AUDIO_WAVE_W-2:0]        tri_fold;  // folded lower bits
    logic signed [`AUDIO_WAVE_W-1:0] wave;

    // phase accumulator
    always_ff @(posedge clk_i) begin
        if (reset_i || !gate_i) begin
            phase_q <= '0;  // cleared every clock while ungated
        end else if (step_en_i) begin
            phase_q <= phase_q + `AUDIO_PHASE_W'(freq_i);  // wraps
        end
    end

    assign top      = phase_q[`AUDIO_PHASE_W-1 -: `AUDIO_WAVE_W];
    assign tri_fold = top[`AUDIO_WAVE_W-1] ? ~top[`AUDIO_WAVE_W-2:0]
                                           :  top[`AUDIO_WAVE_W-2:0];

    // waveform shaping, signed 12 bit
    always_comb begin
        case (wave_i)
            WAVE_SAW: begin
                wave = {~top[`AUDIO_WAVE_W-1], top[`AUDIO_WAVE_W-2:0]};  // offset binary
            end
            WAVE_SQUARE: begin
                // msb set gives +2047, clear gives -2048
                wave = top[`AUDIO_WAVE_W-1] ? {1'b0, {(`AUDIO_WAVE_W-1){1'b1}}}
                                            : {1'b1, {(`AUDIO_WAVE_W-1){1'b0}}};
            end
            WAVE_TRIANGLE: begin
                // fold doubled, then msb flip moves it to signed
                wave = {~tri_fold[`AUDIO_WAVE_W-2], tri_fold[`AUDIO_WAVE_W-3:0], 1'b0};
            end
            default: begin
                wave = '0;  // WAVE_OFF
            end
        endcase
    end

    // volume scaling, 12 x 4 fits in 16 signed
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sample_o <= '0;
        end else begin
            sample_o <= wave * $signed({1'b0, vol_i});  // every clock, no enable
        end
    end

    assign osc_o = phase_q[`AUDIO_PHASE_W-1 -: `AUDIO_DATA_W];

endmodule

`default_nettype wire

// File: audio_output.sv
`timescale 1ns/1ps
`default_nettype none

`include "audio_consts.svh"

module audio_output (
    input  wire logic                              clk_i,
    input  wire logic                              reset_i,
    input  wire logic signed [`AUDIO_SAMPLE_W-1:0] samples_i [`AUDIO_NUM_VOICES],
    input  wire logic                              diag_i,
    input  wire logic                              via_cb2_i,
    output logic                                   audio_o
);
    // headroom for all voices plus the click
    localparam int SUM_W = `AUDIO_SAMPLE_W + $clog2(`AUDIO_NUM_VOICES + 1);

    localparam logic signed [SUM_W-1:0] MIX_MAX = SUM_W'((2 ** (`AUDIO_SAMPLE_W - 1)) - 1);
    localparam logic signed [SUM_W-1:0] MIX_MIN = -SUM_W'(2 ** (`AUDIO_SAMPLE_W - 1));
    localparam logic signed [SUM_W-1:0] CLICK   = SUM_W'(`AUDIO_CLICK_LEVEL);

    logic signed [SUM_W-1:0]           sum;
    logic signed [`AUDIO_SAMPLE_W-1:0] mix_q;     // saturated, registered
    logic        [`AUDIO_SAMPLE_W-1:0] mix_u;     // biased unsigned
    logic        [`AUDIO_SAMPLE_W:0]   dsm_acc_q; // carry in msb

    // click is high only when diag and cb2 agree
    always_comb begin
        sum = (via_cb2_i && diag_i) ? CLICK : -CLICK;
        for (int v = 0; v < `AUDIO_NUM_VOICES; v++) begin
            sum = sum + SUM_W'(samples_i[v]);  // sign extends
        end
    end

    // clamp to 16 bit signed
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mix_q <= '0;
        end else if (sum > MIX_MAX) begin
            mix_q <= MIX_MAX[`AUDIO_SAMPLE_W-1:0];
        end else if (sum < MIX_MIN) begin
            mix_q <= MIX_MIN[`AUDIO_SAMPLE_W-1:0];
        end else begin
            mix_q <= sum[`AUDIO_SAMPLE_W-1:0];
        end
    end

    // + 0x8000 is just the msb flipped
    assign mix_u = {~mix_q[`AUDIO_SAMPLE_W-1], mix_q[`AUDIO_SAMPLE_W-2:0]};

    // first order delta sigma, runs every clock
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dsm_acc_q <= '0;
        end else begin
            dsm_acc_q <= dsm_acc_q[`AUDIO_SAMPLE_W-1:0] + mix_u;  // carry lands in msb
        end
    end

    assign audio_o = dsm_acc_q[`AUDIO_SAMPLE_W];  // carry drives the pin

endmodule

`default_nettype wire

// File: audio.sv
`timescale 1ns/1ps
`default_nettype none

`include "audio_consts.svh"

module audio import audio_pkg::*; (
    input  wire logic                     reset_i,
    input  wire logic                     clk_i,
    input  wire logic                     clk1_en_i,        // one clock in N
    input  wire logic                     sid_en_i,         // chip select
    input  wire logic                     cpu_wr_strobe_i,  // single cycle
    input  wire logic [`AUDIO_ADDR_W-1:0] addr_i,
    input  wire logic [`AUDIO_DATA_W-1:0] data_i,
    output logic      [`AUDIO_DATA_W-1:0] data_o,           // combinational read
    input  wire logic                     diag_i,
    input  wire logic                     via_cb2_i,
    output logic                          audio_o
);
    logic                                            wr_en;
    logic [`AUDIO_NUM_VOICES-1:0][`AUDIO_FREQ_W-1:0] freq;
    wave_e [`AUDIO_NUM_VOICES-1:0]                   wave;
    logic [`AUDIO_NUM_VOICES-1:0]                    gate;
    logic [`AUDIO_NUM_VOICES-1:0][`AUDIO_VOL_W-1:0]  vol;
    logic signed [`AUDIO_SAMPLE_W-1:0]               samples [`AUDIO_NUM_VOICES];
    logic [`AUDIO_DATA_W-1:0]                        osc     [`AUDIO_NUM_VOICES];

    assign wr_en = cpu_wr_strobe_i && sid_en_i;  // writes never stall

    sound_regs u_regs (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .wr_en_i (wr_en),
        .addr_i  (addr_i),
        .data_i  (data_i),
        .osc0_i  (osc[0]),  // only voice 0 is readable
        .data_o  (data_o),
        .freq_o  (freq),
        .wave_o  (wave),
        .gate_o  (gate),
        .vol_o   (vol)
    );

    // one voice per slot in the register map
    for (genvar v = 0; v < `AUDIO_NUM_VOICES; v++) begin : g_voice
        tone_voice u_voice (
            .clk_i     (clk_i),
            .reset_i   (reset_i),
            .step_en_i (clk1_en_i),
            .freq_i    (freq[v]),
            .wave_i    (wave[v]),
            .gate_i    (gate[v]),
            .vol_i     (vol[v]),
            .sample_o  (samples[v]),
            .osc_o     (osc[v])
        );
    end

    // mixer and pin driver
    audio_output u_out (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .samples_i (samples),
        .diag_i    (diag_i),
        .via_cb2_i (via_cb2_i),
        .audio_o   (audio_o)
    );

endmodule

`default_nettype wire

// File: audio_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "audio_consts.svh"

module audio_properties import audio_pkg::*; (
    input wire logic                                            clk_i,
    input wire logic                                            reset_i,
    input wire logic        [`AUDIO_ADDR_W-1:0]                 addr_i,
    input wire logic        [`AUDIO_DATA_W-1:0]                 data_o,
    input wire logic                                            audio_o,
    input wire logic        [`AUDIO_NUM_VOICES-1:0]             gate_i,
    input wire logic        [`AUDIO_NUM_VOICES-1:0][1:0]        wave_i,
    input wire logic        [`AUDIO_NUM_VOICES-1:0][`AUDIO_VOL_W-1:0] vol_i,
    input wire logic signed [`AUDIO_SAMPLE_W-1:0]               samples_i [`AUDIO_NUM_VOICES]
);
    int fail_cnt = 0;  // failed assertions so far

    // pin low right out of reset
    a_reset_low: assert property (@(posedge clk_i) reset_i |=> !audio_o)
        else begin
            $error("audio_o high in the cycle after reset");
            fail_cnt++;
        end

    a_unmapped: assert property (@(posedge clk_i) disable iff (reset_i)
        !(addr_i inside {[5'd0:5'd7], REG_OSC0}) |-> data_o == '0)
        else begin
            $error("unmapped address read back nonzero");
            fail_cnt++;
        end

    // silent voice gives a zero sample next clock
    for (genvar v = 0; v < `AUDIO_NUM_VOICES; v++) begin : g_silent
        a_silent: assert property (@(posedge clk_i) disable iff (reset_i)
            (!gate_i[v] && (wave_i[v] == WAVE_OFF || vol_i[v] == '0)) |=> samples_i[v] == '0)
            else begin
                $error("voice %0d sample not zero while silent", v);
                fail_cnt++;
            end
    end

endmodule

bind audio audio_properties u_props (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .addr_i    (addr_i),
    .data_o    (data_o),
    .audio_o   (audio_o),
    .gate_i    (gate),
    .wave_i    (wave),
    .vol_i     (vol),
    .samples_i (samples)
);

`default_nettype wire

// File: tb_audio.sv
`timescale 1ns/1ps
`default_nettype none

`include "audio_consts.svh"

module tb_audio import audio_pkg::*; ();
    localparam int NV    = `AUDIO_NUM_VOICES;
    localparam int CLICK = `AUDIO_CLICK_LEVEL;

    logic       clk_i;
    logic       reset_i;
    logic       clk1_en_i;
    logic       sid_en_i;
    logic       cpu_wr_strobe_i;
    logic [4:0] addr_i;
    logic [7:0] data_i;
    logic [7:0] data_o;
    logic       diag_i;
    logic       via_cb2_i;
    logic       audio_o;

    // reference model
    logic [7:0]  m_freq_lo [NV];
    logic [7:0]  m_freq_hi [NV];
    logic [2:0]  m_ctrl    [NV];  // gate, wave
    logic [3:0]  m_vol     [NV];
    logic [23:0] m_phase   [NV];
    int          m_sample  [NV];
    int          m_mix;           // saturated mix
    logic [16:0] m_acc;           // modulator, carry on top

    logic [31:0] rng = 32'd32318;
    logic        stepped;         // enable seen at the last edge
    int          en_cnt       = 0;
    int          dut_ones     = 0;
    int          model_ones   = 0;
    int          test_errs    = 0;
    int          total_errs   = 0;
    int          tests_failed = 0;
    int          test_num     = 0;

    audio DUT (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // signed 12 bit shape from the phase top bits
    function automatic int wave_value(logic [23:0] phase, logic [1:0] wave);
        int top;
        top = int'(phase[23:12]);
        case (wave)
            WAVE_SAW:      return top - 2048;                         // msb flipped
            WAVE_SQUARE:   return (top >= 2048) ? 2047 : -2048;
            WAVE_TRIANGLE: return 2 * ((top >= 2048) ? 4095 - top : top) - 2048;
            default:       return 0;
        endcase
    endfunction

    function automatic logic [7:0] model_read(logic [4:0] a);
        if (a == REG_OSC0) return m_phase[0][23:16];
        if (int'(a[4:2]) >= NV) return 8'h00;  // unmapped
        case (a[1:0])
            2'd0:    return m_freq_lo[a[4:2]];
            2'd1:    return m_freq_hi[a[4:2]];
            2'd2:    return {5'b0, m_ctrl[a[4:2]]};
            default: return {4'b0, m_vol[a[4:2]]};
        endcase
    endfunction

    // one clock of the model, from the values before the edge
    task automatic update_model();
        int          v;
        int          sum;
        int          nxt_sample [NV];
        logic [23:0] nxt_phase  [NV];
        logic [16:0] nxt_acc;
        if (reset_i) begin
            for (v = 0; v < NV; v++) begin
                m_freq_lo[v] = '0;
                m_freq_hi[v] = '0;
                m_ctrl[v]    = '0;
                m_vol[v]     = '0;
                m_phase[v]   = '0;
                m_sample[v]  = 0;
            end
            m_mix = 0;
            m_acc = '0;
            return;
        end
        nxt_acc = {1'b0, m_acc[15:0]} + 17'((m_mix + 32768) & 32'hffff);  // biased mix
        sum = (via_cb2_i && diag_i) ? CLICK : -CLICK;
        for (v = 0; v < NV; v++) begin
            sum = sum + m_sample[v];
            nxt_sample[v] = wave_value(m_phase[v], m_ctrl[v][1:0]) * int'(m_vol[v]);
            if (!m_ctrl[v][2])  nxt_phase[v] = '0;                              // held
            else if (clk1_en_i) nxt_phase[v] = m_phase[v] + {m_freq_hi[v], m_freq_lo[v]};
            else                nxt_phase[v] = m_phase[v];
        end
        if (sum > 32767) sum = 32767;
        else if (sum < -32768) sum = -32768;
        if (cpu_wr_strobe_i && sid_en_i && int'(addr_i[4:2]) < NV) begin
            case (addr_i[1:0])
                2'd0:    m_freq_lo[addr_i[4:2]] = data_i;
                2'd1:    m_freq_hi[addr_i[4:2]] = data_i;
                2'd2:    m_ctrl[addr_i[4:2]]    = data_i[2:0];
                default: m_vol[addr_i[4:2]]     = data_i[3:0];
            endcase
        end
        for (v = 0; v < NV; v++) begin
            m_phase[v]  = nxt_phase[v];
            m_sample[v] = nxt_sample[v];
        end
        m_mix = sum;
        m_acc = nxt_acc;
    endtask

    task automatic run_cycle();
        @(posedge clk_i);
        stepped = clk1_en_i;
        update_model();
        #1;
        en_cnt++;
        clk1_en_i       = (en_cnt % 4 == 3);  // 1 MHz tick, one in four
        cpu_wr_strobe_i = 1'b0;               // strobe is one clock wide
        dut_ones   += audio_o;
        model_ones += m_acc[16];
        assert (audio_o === m_acc[16]) else begin
            $display("FAILED %0t audio_o got %b expected %b", $time, audio_o, m_acc[16]);
            test_errs++;
        end
    endtask

    task automatic read_expect(logic [4:0] a, logic [7:0] exp);
        addr_i = a;
        #1;
        assert (data_o === exp) else begin
            $display("FAILED %0t data_o (addr %0d) got %h expected %h", $time, a, data_o, exp);
            test_errs++;
        end
        run_cycle();
    endtask

    task automatic read_check(logic [4:0] a);
        read_expect(a, model_read(a));
    endtask

    task automatic write_reg(logic [4:0] a, logic [7:0] d, logic sel);
        addr_i          = a;
        data_i          = d;
        sid_en_i        = sel;
        cpu_wr_strobe_i = 1'b1;
        run_cycle();
    endtask

    task automatic wait_enables(int n);
        int seen;
        int guard;
        seen  = 0;
        guard = 0;
        while (seen < n && guard < 8 * n + 8) begin
            run_cycle();
            if (stepped) seen++;
            guard++;
        end
        if (seen < n) begin
            $display("timeout: saw only %0d of %0d clk1 enable pulses", seen, n);
            test_errs++;
        end
    endtask

    task automatic end_test(string name);
        test_num++;
        if (test_errs == 0) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        test_errs   = 0;
    endtask

    initial begin
        int a;
        int v;
        int w;
        int guard;
        clk_i           = 1'b0;
        reset_i         = 1'b1;
        clk1_en_i       = 1'b0;
        sid_en_i        = 1'b0;
        cpu_wr_strobe_i = 1'b0;
        addr_i          = '0;
        data_i          = '0;
        diag_i          = 1'b0;
        via_cb2_i       = 1'b0;
        repeat (8) run_cycle();
        reset_i = 1'b0;
        guard   = 0;
        while (audio_o !== 1'b0 && guard < 16) begin  // pin must be low out of reset
            run_cycle();
            guard++;
        end
        if (audio_o !== 1'b0) begin
            $display("timeout: audio_o never went low after reset");
            test_errs++;
        end

        for (a = 0; a < 8; a++) read_expect(a, 8'h00);
        read_expect(REG_OSC0, 8'h00);
        end_test("reset state");

        repeat (40) begin
            a = next_rand() % 8;
            write_reg(a, next_rand(), 1'b1);
            read_check(a);
        end
        repeat (20) write_reg(next_rand() % 8, next_rand(), 1'b0);  // deselected
        for (a = 0; a < 8; a++) read_check(a);
        repeat (20) begin
            a = 8 + next_rand() % 24;
            if (a == REG_OSC0) a = 31;
            read_expect(a, 8'h00);
        end
        end_test("register read-back");

        write_reg(REG_V0_FREQ_LO, next_rand(), 1'b1);
        write_reg(REG_V0_FREQ_HI, 8'h80 | next_rand(), 1'b1);  // big step, osc byte moves
        write_reg(REG_V0_CTRL, 8'h04 | (next_rand() % 4), 1'b1);  // gate on
        repeat (6) begin
            wait_enables(1 + next_rand() % 8);
            read_check(REG_OSC0);
        end
        write_reg(REG_V0_CTRL, 8'h00, 1'b1);
        wait_enables(3);
        read_expect(REG_OSC0, 8'h00);  // gate clear holds zero
        end_test("phase stepping");

        for (w = 0; w < 4; w++) begin
            for (v = 0; v < NV; v++) begin
                write_reg(4 * v + 0, next_rand(), 1'b1);
                write_reg(4 * v + 1, next_rand(), 1'b1);
                write_reg(4 * v + 2, 4 + w, 1'b1);
                write_reg(4 * v + 3, next_rand(), 1'b1);
            end
            wait_enables(64);
        end
        end_test("waveforms and volume");

        diag_i    = 1'b1;
        via_cb2_i = 1'b1;  // click high
        a = next_rand();   // same step on both voices
        for (v = 0; v < NV; v++) begin
            write_reg(4 * v + 2, 8'h00, 1'b1);  // gate off clears phase
            write_reg(4 * v + 0, a, 1'b1);
            write_reg(4 * v + 1, a >> 8, 1'b1);
            write_reg(4 * v + 3, 8'h0f, 1'b1);
        end
        for (v = 0; v < NV; v++) write_reg(4 * v + 2, 4 + WAVE_SQUARE, 1'b1);  // in phase
        wait_enables(4);
        dut_ones   = 0;
        model_ones = 0;
        repeat (256) run_cycle();
        assert (dut_ones == model_ones) else begin
            $display("FAILED %0t audio_o ones count got %0d expected %0d",
                     $time, dut_ones, model_ones);
            test_errs++;
        end
        end_test("click and saturation");

        repeat (3000) begin
            case (next_rand() % 8)
                0, 1:    write_reg(next_rand() % 8, next_rand(), (next_rand() % 4) != 0);
                2: begin
                    via_cb2_i = ~via_cb2_i;
                    run_cycle();
                end
                3: begin
                    diag_i = (next_rand() % 8) != 0;  // mostly on
                    run_cycle();
                end
                4, 5:    read_check(next_rand() % 32);
                default: run_cycle();
            endcase
        end
        end_test("random soak");

        $display("%0d tests run, %0d failed, %0d errors, %0d property failures",
                 test_num, tests_failed, total_errs, DUT.u_props.fail_cnt);
        if (total_errs == 0 && DUT.u_props.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
audio_pkg.sv
sound_regs.sv
tone_voice.sv
audio_output.sv
audio.sv
audio_properties.sv
tb_audio.sv

// File: Bender.yml
package:
  name: audio

sources:
  - include_dirs:
      - .
    files:
      - audio_pkg.sv
      - sound_regs.sv
      - tone_voice.sv
      - audio_output.sv
      - audio.sv
  - target: test
    include_dirs:
      - .
    files:
      - audio_properties.sv
      - tb_audio.sv
